//--- files.f
src/dnc_pkg.sv
src/dnc_write_key.sv
src/dnc_content_match.sv
src/dnc_memory.sv
src/dnc_write_head.sv
verif/dnc_write_head_tb.sv

//--- run.sh
#!/bin/sh
# Build the DNC write head testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
  --top-module dnc_write_head_tb -f files.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vdnc_write_head_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# Result comes from the testbench's own report
if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/dnc_write_head_tb.sv
// Testbench for the DNC write head with directed and random tests against a memory model
`timescale 1ns/1ns
`default_nettype none

module dnc_write_head_tb;

  // Limit at about twice the length of all tests
  localparam int TIMEOUT_CYCLES = 2000;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                                 CLK;
  logic                                 RST;
  logic                                 start;
  logic        [dnc_pkg::INDEX_SIZE-1:0] size_w_in;
  logic                                 k_in_enable;
  logic signed [dnc_pkg::DATA_SIZE-1:0]  k_in;
  logic                                 v_in_enable;
  logic signed [dnc_pkg::DATA_SIZE-1:0]  v_in;
  logic                                 load_enable;
  logic        [dnc_pkg::ROW_SIZE-1:0]   load_row;
  logic        [dnc_pkg::INDEX_SIZE-1:0] load_index;
  logic signed [dnc_pkg::DATA_SIZE-1:0]  load_data;
  logic        [dnc_pkg::ROW_SIZE-1:0]   r_row;
  logic        [dnc_pkg::INDEX_SIZE-1:0] r_index;
  logic                                 ready;
  logic                                 k_out_enable;
  logic signed [dnc_pkg::DATA_SIZE-1:0]  k_out;
  logic                                 match_done;
  logic        [dnc_pkg::ROW_SIZE-1:0]   match_addr;
  logic                                 write_done;
  logic signed [dnc_pkg::DATA_SIZE-1:0]  r_data;

  // Reference memory and the vectors of the next operation
  int model_mem [dnc_pkg::N_ROWS][dnc_pkg::W_MAX];
  int key_vec [dnc_pkg::W_MAX];
  int val_vec [dnc_pkg::W_MAX];
  int key_gap [dnc_pkg::W_MAX];
  int val_gap [dnc_pkg::W_MAX];

  int seed;
  int error_count;
  int test_start_errors;
  int tests_passed;
  int tests_failed;
  int cycle_count;

  dnc_write_head DUT (
    .CLK          (CLK),
    .RST          (RST),
    .START        (start),
    .SIZE_W_IN    (size_w_in),
    .K_IN_ENABLE  (k_in_enable),
    .K_IN         (k_in),
    .READY        (ready),
    .K_OUT_ENABLE (k_out_enable),
    .K_OUT        (k_out),
    .V_IN_ENABLE  (v_in_enable),
    .V_IN         (v_in),
    .LOAD_ENABLE  (load_enable),
    .LOAD_ROW     (load_row),
    .LOAD_INDEX   (load_index),
    .LOAD_DATA    (load_data),
    .R_ROW        (r_row),
    .R_INDEX      (r_index),
    .MATCH_DONE   (match_done),
    .MATCH_ADDR   (match_addr),
    .WRITE_DONE   (write_done),
    .R_DATA       (r_data)
  );

  // 4 ns clock
  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  ////////////////////
  // Helpers
  ////////////////////

  // Next rising edge plus 1 ns for outputs to settle and inputs to change
  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic report_mismatch(input string what, input int got, input int expected);
    $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, expected);
    error_count++;
  endtask

  task automatic load_element(input int row, input int idx, input int data);
    load_enable = 1'b1;
    load_row    = dnc_pkg::ROW_SIZE'(row);
    load_index  = dnc_pkg::INDEX_SIZE'(idx);
    load_data   = dnc_pkg::DATA_SIZE'(data);
    tick();
    load_enable = 1'b0;
    model_mem[row][idx] = data;
  endtask

  // Whole memory through the read-back port
  task automatic check_memory();
    for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
      for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
        r_row   = dnc_pkg::ROW_SIZE'(r);
        r_index = dnc_pkg::INDEX_SIZE'(c);
        #1;
        if (r_data !== dnc_pkg::DATA_SIZE'(model_mem[r][c]))
          report_mismatch($sformatf("R_DATA row %0d index %0d", r, c), int'(r_data),
                          model_mem[r][c]);
      end
    end
    tick();
  endtask

  // Largest dot product over the first size columns with ties to the lower row
  function automatic int model_argmax(input int size);
    longint best;
    longint sum;
    int     best_row;
    best     = 0;
    best_row = 0;
    for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
      sum = 0;
      for (int c = 0; c < size; c++) begin
        sum += longint'(key_vec[c]) * longint'(model_mem[r][c]);
      end
      if (r == 0 || sum > best) begin
        best     = sum;
        best_row = r;
      end
    end
    return best_row;
  endfunction

  task automatic set_gaps(input int kg, input int vg);
    for (int i = 0; i < dnc_pkg::W_MAX; i++) begin
      key_gap[i] = kg;
      val_gap[i] = vg;
    end
  endtask

  // Full operation from START through key and match to the value write
  task automatic run_operation(input int size);
    int exp_row;
    exp_row   = model_argmax(size);
    start     = 1'b1;
    size_w_in = dnc_pkg::INDEX_SIZE'(size);
    tick();
    start = 1'b0;
    for (int i = 0; i < size; i++) begin
      for (int g = 0; g < key_gap[i]; g++) begin
        k_in_enable = 1'b0;
        tick();
        if (k_out_enable !== 1'b0) report_mismatch("K_OUT_ENABLE in gap", int'(k_out_enable), 0);
        if (ready !== 1'b0) report_mismatch("READY in gap", int'(ready), 0);
      end
      k_in_enable = 1'b1;
      k_in        = dnc_pkg::DATA_SIZE'(key_vec[i]);
      tick();
      // Registered copy one cycle after its enable
      if (k_out_enable !== 1'b1) report_mismatch("K_OUT_ENABLE", int'(k_out_enable), 1);
      if (k_out !== dnc_pkg::DATA_SIZE'(key_vec[i]))
        report_mismatch("K_OUT", int'(k_out), key_vec[i]);
      if (ready !== (i == size - 1)) report_mismatch("READY", int'(ready), int'(i == size - 1));
      if (match_done !== 1'b0) report_mismatch("MATCH_DONE early", int'(match_done), 0);
    end
    k_in_enable = 1'b0;
    tick();
    // Two cycles after the last key element
    if (match_done !== 1'b1) report_mismatch("MATCH_DONE", int'(match_done), 1);
    if (match_addr !== dnc_pkg::ROW_SIZE'(exp_row))
      report_mismatch("MATCH_ADDR", int'(match_addr), exp_row);
    if (ready !== 1'b0) report_mismatch("READY after key", int'(ready), 0);
    tick();
    if (match_done !== 1'b0) report_mismatch("MATCH_DONE width", int'(match_done), 0);
    // Memory is in its row write state from here
    for (int i = 0; i < size; i++) begin
      for (int g = 0; g < val_gap[i]; g++) begin
        v_in_enable = 1'b0;
        tick();
        if (write_done !== 1'b0) report_mismatch("WRITE_DONE in gap", int'(write_done), 0);
      end
      v_in_enable = 1'b1;
      v_in        = dnc_pkg::DATA_SIZE'(val_vec[i]);
      tick();
      if (write_done !== (i == size - 1))
        report_mismatch("WRITE_DONE", int'(write_done), int'(i == size - 1));
    end
    v_in_enable = 1'b0;
    tick();
    if (write_done !== 1'b0) report_mismatch("WRITE_DONE width", int'(write_done), 0);
    for (int i = 0; i < size; i++) begin
      model_mem[exp_row][i] = val_vec[i];
    end
  endtask

  task automatic finish_test(input string name);
    if (error_count == test_start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    if (ready !== 1'b0) report_mismatch("READY after reset", int'(ready), 0);
    if (k_out_enable !== 1'b0) report_mismatch("K_OUT_ENABLE after reset", int'(k_out_enable), 0);
    if (match_done !== 1'b0) report_mismatch("MATCH_DONE after reset", int'(match_done), 0);
    if (write_done !== 1'b0) report_mismatch("WRITE_DONE after reset", int'(write_done), 0);
    check_memory();
    finish_test("reset_state");
  endtask

  task automatic test_key_pass_through();
    key_vec = '{3, -7, 12, -1, 5, 0, 0, 0};
    val_vec = '{10, 20, 30, 40, 50, 0, 0, 0};
    set_gaps(0, 0);
    key_gap = '{0, 2, 1, 0, 3, 0, 0, 0};
    run_operation(5);
    check_memory();
    finish_test("key_pass_through");
  endtask

  task automatic test_row_selection();
    // Pattern over the whole address
    for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
      for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
        load_element(r, c, ((r * 8 + c) * 7) % 23 - 11);
      end
    end
    set_gaps(0, 0);
    key_vec = '{2, -3, 5, 1, 0, 0, 0, 0};
    val_vec = '{60, 61, 62, 63, 0, 0, 0, 0};
    run_operation(4);
    key_vec = '{-4, 0, 0, 0, 0, 0, 0, 0};
    val_vec = '{-70, 0, 0, 0, 0, 0, 0, 0};
    run_operation(1);
    key_vec = '{1, 2, -1, 3, -2, 4, 0, -5};
    val_vec = '{81, 82, 83, 84, 85, 86, 87, 88};
    run_operation(8);
    check_memory();
    finish_test("row_selection");
  endtask

  task automatic test_tie_break();
    // Rows 2 and 5 share the top score
    for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
      for (int c = 0; c < 4; c++) begin
        load_element(r, c, (r == 2 || r == 5) ? 9 + c : r - 4 + c);
      end
    end
    set_gaps(0, 0);
    key_vec = '{1, 1, 1, 1, 0, 0, 0, 0};
    val_vec = '{7, 7, 7, 7, 0, 0, 0, 0};
    run_operation(4);
    if (match_addr !== 3'd2) report_mismatch("MATCH_ADDR on tie", int'(match_addr), 2);
    finish_test("tie_break");
  endtask

  task automatic test_row_write();
    set_gaps(0, 0);
    key_vec = '{1, 1, 1, 1, 1, 1, 0, 0};
    val_vec = '{-5, 6, -7, 8, -9, 10, 0, 0};
    val_gap = '{1, 0, 2, 0, 1, 3, 0, 0};
    run_operation(6);
    check_memory();
    finish_test("row_write");
  endtask

  task automatic test_random_rounds();
    int size;
    for (int round = 0; round < 10; round++) begin
      repeat (16) load_element($random(seed) & 7, $random(seed) & 7, $random(seed) % 32);
      size = ($random(seed) & 7) + 1;
      for (int i = 0; i < dnc_pkg::W_MAX; i++) begin
        key_vec[i] = $random(seed) % 16;
        val_vec[i] = $random(seed) % 100;
        key_gap[i] = $random(seed) & 1;
        val_gap[i] = $random(seed) & 1;
      end
      run_operation(size);
      check_memory();
    end
    finish_test("random_rounds");
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed              = 32'h270d_4853;
    error_count       = 0;
    test_start_errors = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
      for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
        model_mem[r][c] = 0;
      end
    end
    RST         = 1'b1;
    start       = 1'b0;
    size_w_in   = '0;
    k_in_enable = 1'b0;
    k_in        = '0;
    v_in_enable = 1'b0;
    v_in        = '0;
    load_enable = 1'b0;
    load_row    = '0;
    load_index  = '0;
    load_data   = '0;
    r_row       = '0;
    r_index     = '0;
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b0;
    test_reset_state();
    test_key_pass_through();
    test_row_selection();
    test_tie_break();
    test_row_write();
    test_random_rounds();
    $display("tests passed %0d, tests failed %0d, mismatches %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Stops a hung run
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/dnc_write_head.sv
// Write head top level with key stage, content matcher and row memory
`timescale 1ns/1ns
`default_nettype none

module dnc_write_head (
  // Clock and reset
  input  logic                                 CLK,
  input  logic                                 RST,

  // Operation control
  input  logic                                 START,
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] SIZE_W_IN,

  // Key stream
  input  logic                                 K_IN_ENABLE,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  K_IN,
  output logic                                 READY,
  output logic                                 K_OUT_ENABLE,
  output logic signed [dnc_pkg::DATA_SIZE-1:0]  K_OUT,

  // Value stream
  input  logic                                 V_IN_ENABLE,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  V_IN,

  // Direct load
  input  logic                                 LOAD_ENABLE,
  input  logic        [dnc_pkg::ROW_SIZE-1:0]   LOAD_ROW,
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] LOAD_INDEX,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  LOAD_DATA,

  // Read-back
  input  logic        [dnc_pkg::ROW_SIZE-1:0]   R_ROW,
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] R_INDEX,

  // Results
  output logic                                 MATCH_DONE,
  output logic        [dnc_pkg::ROW_SIZE-1:0]   MATCH_ADDR,
  output logic                                 WRITE_DONE,
  output logic signed [dnc_pkg::DATA_SIZE-1:0]  R_DATA
);

  ////////////////////
  // Internal nets
  ////////////////////

  // Matcher column address and the column it selects
  logic [dnc_pkg::INDEX_SIZE-1:0] match_column;
  dnc_pkg::column_t               column_data;

  // Key in, registered key out
  dnc_write_key u_write_key (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .K_IN_ENABLE  (K_IN_ENABLE),
    .K_OUT_ENABLE (K_OUT_ENABLE),
    .SIZE_W_IN    (SIZE_W_IN),
    .K_IN         (K_IN),
    .K_OUT        (K_OUT)
  );

  // Scores rows as key elements pass
  dnc_content_match u_content_match (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .K_OUT_ENABLE (K_OUT_ENABLE),
    .K_OUT        (K_OUT),
    .MATCH_COLUMN (match_column),
    .COLUMN_DATA  (column_data),
    .MATCH_DONE   (MATCH_DONE),
    .MATCH_ADDR   (MATCH_ADDR)
  );

  // Storage that takes the winning row for the value write
  dnc_memory u_memory (
    .CLK          (CLK),
    .RST          (RST),
    .LOAD_ENABLE  (LOAD_ENABLE),
    .LOAD_ROW     (LOAD_ROW),
    .LOAD_INDEX   (LOAD_INDEX),
    .LOAD_DATA    (LOAD_DATA),
    .MATCH_COLUMN (match_column),
    .COLUMN_DATA  (column_data),
    .MATCH_DONE   (MATCH_DONE),
    .MATCH_ADDR   (MATCH_ADDR),
    .SIZE_W_IN    (SIZE_W_IN),
    .V_IN_ENABLE  (V_IN_ENABLE),
    .V_IN         (V_IN),
    .WRITE_DONE   (WRITE_DONE),
    .R_ROW        (R_ROW),
    .R_INDEX      (R_INDEX),
    .R_DATA       (R_DATA)
  );

endmodule

`default_nettype wire

//--- src/dnc_memory.sv
// Row memory with load port, streamed row write, matcher column port and read-back port
`timescale 1ns/1ns
`default_nettype none

module dnc_memory (
  // Clock and reset
  input  logic                                 CLK,
  input  logic                                 RST,

  // Direct load
  input  logic                                 LOAD_ENABLE,
  input  logic        [dnc_pkg::ROW_SIZE-1:0]   LOAD_ROW,
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] LOAD_INDEX,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  LOAD_DATA,

  // Matcher column
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] MATCH_COLUMN,
  output dnc_pkg::column_t                      COLUMN_DATA,

  // Row write
  input  logic                                 MATCH_DONE,
  input  logic        [dnc_pkg::ROW_SIZE-1:0]   MATCH_ADDR,
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] SIZE_W_IN,
  input  logic                                 V_IN_ENABLE,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  V_IN,
  output logic                                 WRITE_DONE,

  // Read-back
  input  logic        [dnc_pkg::ROW_SIZE-1:0]   R_ROW,
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] R_INDEX,
  output logic signed [dnc_pkg::DATA_SIZE-1:0]  R_DATA
);

  ////////////////////
  // Signals
  ////////////////////

  dnc_pkg::data_t mem [dnc_pkg::N_ROWS][dnc_pkg::W_MAX];

  dnc_pkg::write_state_t state;

  // Latched target row and next element index
  logic [dnc_pkg::ROW_SIZE-1:0]   w_row;
  logic [dnc_pkg::INDEX_SIZE-1:0] w_index;
  logic [dnc_pkg::INDEX_SIZE-1:0] last_index;

  assign last_index = SIZE_W_IN - dnc_pkg::INDEX_SIZE'(1);

  ////////////////////
  // Read ports
  ////////////////////

  // Out-of-range index reads zero
  always_comb begin
    COLUMN_DATA = '0;
    R_DATA      = '0;
    for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
      if (MATCH_COLUMN == dnc_pkg::INDEX_SIZE'(c)) begin
        for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
          COLUMN_DATA[r] = mem[r][c];
        end
      end
      if (R_INDEX == dnc_pkg::INDEX_SIZE'(c)) begin
        R_DATA = mem[R_ROW][c];
      end
    end
  end

  ////////////////////
  // Write side
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= dnc_pkg::WRITE_IDLE;
      w_row      <= '0;
      w_index    <= '0;
      WRITE_DONE <= 1'b0;
      for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
        for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else begin
      // Load port used only while idle
      if (LOAD_ENABLE) begin
        for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
          if (LOAD_INDEX == dnc_pkg::INDEX_SIZE'(c)) begin
            mem[LOAD_ROW][c] <= LOAD_DATA;
          end
        end
      end
      case (state)
        dnc_pkg::WRITE_IDLE: begin
          WRITE_DONE <= 1'b0;
          if (MATCH_DONE) begin
            w_row   <= MATCH_ADDR;
            w_index <= '0;
            state   <= dnc_pkg::WRITE_ROW;
          end
        end
        dnc_pkg::WRITE_ROW: begin
          if (V_IN_ENABLE) begin
            for (int c = 0; c < dnc_pkg::W_MAX; c++) begin
              if (w_index == dnc_pkg::INDEX_SIZE'(c)) begin
                mem[w_row][c] <= V_IN;
              end
            end
            if (w_index == last_index) begin
              // Row complete
              WRITE_DONE <= 1'b1;
              state      <= dnc_pkg::WRITE_IDLE;
            end else begin
              w_index <= w_index + dnc_pkg::INDEX_SIZE'(1);
            end
          end
        end
        default: begin
          state <= dnc_pkg::WRITE_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/dnc_content_match.sv
// Content matcher with per-row signed dot products against the key and argmax row select
`timescale 1ns/1ns
`default_nettype none

module dnc_content_match (
  // Clock and reset
  input  logic                                 CLK,
  input  logic                                 RST,

  // Control from the controller and the key stage
  input  logic                                 START,
  input  logic                                 READY,
  input  logic                                 K_OUT_ENABLE,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  K_OUT,

  // Column access into the memory
  output logic        [dnc_pkg::INDEX_SIZE-1:0] MATCH_COLUMN,
  input  dnc_pkg::column_t                      COLUMN_DATA,

  // Match result
  output logic                                 MATCH_DONE,
  output logic        [dnc_pkg::ROW_SIZE-1:0]   MATCH_ADDR
);

  ////////////////////
  // Signals
  ////////////////////

  dnc_pkg::match_state_t state;

  // One accumulator per memory row
  logic signed [dnc_pkg::ACC_SIZE-1:0] acc      [dnc_pkg::N_ROWS];
  logic signed [dnc_pkg::ACC_SIZE-1:0] acc_next [dnc_pkg::N_ROWS];

  // Argmax over the updated sums
  logic        [dnc_pkg::ROW_SIZE-1:0] best_row;
  logic signed [dnc_pkg::ACC_SIZE-1:0] best_val;

  ////////////////////
  // Dot products
  ////////////////////

  // Each row adds key times its column element at accumulator width
  always_comb begin
    logic signed [2*dnc_pkg::DATA_SIZE-1:0] key_ext;
    logic signed [2*dnc_pkg::DATA_SIZE-1:0] elem_ext;
    logic signed [2*dnc_pkg::DATA_SIZE-1:0] prod;
    key_ext = {{dnc_pkg::DATA_SIZE{K_OUT[dnc_pkg::DATA_SIZE-1]}}, K_OUT};
    for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
      elem_ext = {{dnc_pkg::DATA_SIZE{COLUMN_DATA[r][dnc_pkg::DATA_SIZE-1]}},
                  COLUMN_DATA[r]};
      prod = key_ext * elem_ext;
      acc_next[r] = acc[r] + {{(dnc_pkg::ACC_SIZE - 2*dnc_pkg::DATA_SIZE)
                               {prod[2*dnc_pkg::DATA_SIZE-1]}}, prod};
    end
  end

  // Strict compare keeps the lower row on a tie
  always_comb begin
    best_row = '0;
    best_val = acc_next[0];
    for (int r = 1; r < dnc_pkg::N_ROWS; r++) begin
      if (acc_next[r] > best_val) begin
        best_row = dnc_pkg::ROW_SIZE'(r);
        best_val = acc_next[r];
      end
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= dnc_pkg::MATCH_IDLE;
      MATCH_COLUMN <= '0;
      MATCH_DONE   <= 1'b0;
      MATCH_ADDR   <= '0;
      for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
        acc[r] <= '0;
      end
    end else if (START) begin
      // New key restarts the sums from column 0
      state        <= dnc_pkg::MATCH_ACC;
      MATCH_COLUMN <= '0;
      MATCH_DONE   <= 1'b0;
      for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
        acc[r] <= '0;
      end
    end else begin
      case (state)
        dnc_pkg::MATCH_IDLE: begin
          MATCH_DONE <= 1'b0;
        end
        dnc_pkg::MATCH_ACC: begin
          if (K_OUT_ENABLE) begin
            for (int r = 0; r < dnc_pkg::N_ROWS; r++) begin
              acc[r] <= acc_next[r];
            end
            if (READY) begin
              // Argmax of the final sums shows during the select cycle
              MATCH_ADDR <= best_row;
              MATCH_DONE <= 1'b1;
              state      <= dnc_pkg::MATCH_SELECT;
            end else begin
              MATCH_COLUMN <= MATCH_COLUMN + dnc_pkg::INDEX_SIZE'(1);
            end
          end
        end
        dnc_pkg::MATCH_SELECT: begin
          // Single-cycle MATCH_DONE
          MATCH_DONE <= 1'b0;
          state      <= dnc_pkg::MATCH_IDLE;
        end
        default: begin
          state <= dnc_pkg::MATCH_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/dnc_write_key.sv
// Write-key stage that counts key elements, forwards each one registered and flags the last
`timescale 1ns/1ns
`default_nettype none

module dnc_write_key (
  // Clock and reset
  input  logic                                 CLK,
  input  logic                                 RST,

  // Control
  input  logic                                 START,
  output logic                                 READY,
  input  logic                                 K_IN_ENABLE,
  output logic                                 K_OUT_ENABLE,

  // Data
  input  logic        [dnc_pkg::INDEX_SIZE-1:0] SIZE_W_IN,
  input  logic signed [dnc_pkg::DATA_SIZE-1:0]  K_IN,
  output logic signed [dnc_pkg::DATA_SIZE-1:0]  K_OUT
);

  ////////////////////
  // Signals
  ////////////////////

  dnc_pkg::write_key_state_t state;

  // Elements accepted so far
  logic [dnc_pkg::INDEX_SIZE-1:0] index_loop;
  logic [dnc_pkg::INDEX_SIZE-1:0] last_index;

  ////////////////////
  // Body
  ////////////////////

  // Index of the final key element
  assign last_index = SIZE_W_IN - dnc_pkg::INDEX_SIZE'(1);

  // Key forwarded one element per enable
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= dnc_pkg::STARTER_STATE;
      index_loop   <= '0;
      READY        <= 1'b0;
      K_OUT_ENABLE <= 1'b0;
      K_OUT        <= '0;
    end else begin
      case (state)
        dnc_pkg::STARTER_STATE: begin
          // Outputs quiet between keys
          READY        <= 1'b0;
          K_OUT_ENABLE <= 1'b0;
          if (START) begin
            index_loop <= '0;
            state      <= dnc_pkg::ENDER_STATE;
          end
        end
        dnc_pkg::ENDER_STATE: begin
          // Enable mirrors the input one cycle later including gaps
          K_OUT_ENABLE <= K_IN_ENABLE;
          if (K_IN_ENABLE) begin
            K_OUT <= K_IN;
            if (index_loop == last_index) begin
              // READY rides with the last K_OUT_ENABLE
              READY <= 1'b1;
              state <= dnc_pkg::STARTER_STATE;
            end else begin
              index_loop <= index_loop + dnc_pkg::INDEX_SIZE'(1);
            end
          end
        end
        default: begin
          state <= dnc_pkg::STARTER_STATE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/dnc_pkg.sv
// Shared sizes, element and column types and FSM state enums for the DNC write head
`default_nettype none

package dnc_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // One signed key, memory or value element
  localparam int DATA_SIZE = 16;
  // Element counters and SIZE_W_IN
  localparam int INDEX_SIZE = 4;
  // Elements per memory row
  localparam int W_MAX = 8;
  // Memory rows and row address width
  localparam int N_ROWS = 8;
  localparam int ROW_SIZE = 3;
  // Dot-product accumulator with headroom over eight 32-bit products
  localparam int ACC_SIZE = 40;

  ////////////////////
  // Types
  ////////////////////

  typedef logic signed [DATA_SIZE-1:0] data_t;

  // Elements at one column index across all rows
  typedef data_t [N_ROWS-1:0] column_t;

  typedef enum logic {STARTER_STATE, ENDER_STATE} write_key_state_t;
  typedef enum logic [1:0] {MATCH_IDLE, MATCH_ACC, MATCH_SELECT} match_state_t;
  typedef enum logic {WRITE_IDLE, WRITE_ROW} write_state_t;

endpackage

`default_nettype wire
